/* rtl/ap_config.svh */
`ifndef AP_CONFIG_SVH
`define AP_CONFIG_SVH

// Operand word width, A and B columns and host data
`define AP_WORD_BITS 8

// Result column, word plus carry in the top bit
`define AP_COL_BITS 9

// Rows per column and row address width
`define AP_ROWS 16
`define AP_ROW_BITS 4

`endif

/* rtl/ap_cam_pkg.sv */
`include "ap_config.svh"

package ap_cam_pkg;

  // Column select for host access
  typedef enum logic [1:0] {
    COL_A = 2'd0,
    COL_B = 2'd1,
    COL_C = 2'd2
  } column_e;

  // One host request, read when write is low
  typedef struct packed {
    logic                     write;
    column_e                  col;
    logic [`AP_ROW_BITS-1:0]  row;
    logic [`AP_WORD_BITS-1:0] data;
  } host_req_t;

  // Single word write into one column
  typedef struct packed {
    logic                     en;
    logic [`AP_ROW_BITS-1:0]  row;
    logic [`AP_WORD_BITS-1:0] data;
  } host_wr_t;

  // Masked search, narrow columns use the low bits
  typedef struct packed {
    logic [`AP_COL_BITS-1:0] key;
    logic [`AP_COL_BITS-1:0] mask;
  } search_t;

  // Parallel masked write into tagged rows
  typedef struct packed {
    logic                    en;
    logic [`AP_COL_BITS-1:0] data;
    logic [`AP_COL_BITS-1:0] mask;
  } par_wr_t;

endpackage

/* rtl/ap_op_pkg.sv */
package ap_op_pkg;

  typedef enum logic [2:0] {
    OP_OR  = 3'd0,
    OP_XOR = 3'd1,
    OP_AND = 3'd2,
    OP_NOT = 3'd3,
    OP_ADD = 3'd4
  } op_e;

  // Logical pass, C starts cleared so only the result bit is written
  typedef struct packed {
    logic       key_a;
    logic       key_b;
    logic       val_c;
    logic [1:0] unused;
  } pass_logic_t;

  // Add pass, carry sits in the top bit of C
  typedef struct packed {
    logic key_a;
    logic key_b;
    logic key_carry;
    logic val_sum;
    logic val_carry;
  } pass_arith_t;

  typedef union packed {
    pass_logic_t lgc;
    pass_arith_t arith;
  } pass_entry_u;

  ////////////////////////////////////////////////////////////
  // Pass table
  ////////////////////////////////////////////////////////////

  // Logical ops walk all four (a, b) pairs, ADD needs five passes
  function automatic pass_entry_u pass_table(input op_e op, input logic [2:0] idx,
                                             output logic [2:0] count);
    pass_entry_u entry;
    logic        a;
    logic        b;
    entry = '0;
    a     = idx[1];
    b     = idx[0];
    count = 3'd4;
    entry.lgc.key_a = a;
    entry.lgc.key_b = b;
    case (op)
      OP_OR:  entry.lgc.val_c = a | b;
      OP_XOR: entry.lgc.val_c = a ^ b;
      OP_AND: entry.lgc.val_c = a & b;
      OP_NOT: entry.lgc.val_c = ~a;
      OP_ADD: begin
        count = 3'd5;
        // Order matters, a rewritten row must not hit a later pass
        case (idx)
          3'd0:    entry.arith = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
          3'd1:    entry.arith = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
          3'd2:    entry.arith = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
          3'd3:    entry.arith = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
          default: entry.arith = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
        endcase
      end
      default: entry = '0;
    endcase
    return entry;
  endfunction

endpackage

/* rtl/cam_column.sv */
`timescale 1ns/1ps
`include "ap_config.svh"

module cam_column
  import ap_cam_pkg::*;
#(
  parameter int WIDTH = 8
) (
  input  logic                    clock,
  input  logic                    rst,
  input  host_wr_t                host_wr,
  input  logic [`AP_ROW_BITS-1:0] read_row,
  output logic [WIDTH-1:0]        read_data,
  input  search_t                 search,
  output logic [`AP_ROWS-1:0]     tags,
  input  par_wr_t                 par_wr,
  input  logic [`AP_ROWS-1:0]     par_rows
);

  logic [WIDTH-1:0] mem [`AP_ROWS];

  logic [WIDTH-1:0] key;
  logic [WIDTH-1:0] mask;
  logic [WIDTH-1:0] wr_data;
  logic [WIDTH-1:0] wr_mask;

  assign key     = search.key[WIDTH-1:0];
  assign mask    = search.mask[WIDTH-1:0];
  assign wr_data = par_wr.data[WIDTH-1:0];
  assign wr_mask = par_wr.mask[WIDTH-1:0];

  ////////////////////////////////////////////////////////////
  // Search
  ////////////////////////////////////////////////////////////

  // A row matches when every unmasked bit equals the key
  always_comb begin
    for (int r = 0; r < `AP_ROWS; r++) begin
      tags[r] = ((mem[r] ^ key) & mask) == '0;
    end
  end

  assign read_data = mem[read_row];

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // No writes land while the design is held in reset
  always_ff @(posedge clock) begin
    if (!rst) begin
      if (par_wr.en) begin
        for (int r = 0; r < `AP_ROWS; r++) begin
          if (par_rows[r]) begin
            mem[r] <= (mem[r] & ~wr_mask) | (wr_data & wr_mask);
          end
        end
      end
      if (host_wr.en) begin
        // Zero extend into the carry column
        mem[host_wr.row] <= WIDTH'(host_wr.data);
      end
    end
  end

endmodule

/* rtl/pass_sequencer.sv */
`timescale 1ns/1ps
`include "ap_config.svh"

module pass_sequencer
  import ap_cam_pkg::*;
  import ap_op_pkg::*;
(
  input  logic                clock,
  input  logic                rst,
  input  op_e                 op,
  input  logic                op_valid,
  output logic                op_ready,
  output logic                op_done,
  input  logic                req_valid,
  output logic                busy,
  output search_t             search_a,
  output search_t             search_b,
  output search_t             search_c,
  input  logic [`AP_ROWS-1:0] tags_a,
  input  logic [`AP_ROWS-1:0] tags_b,
  input  logic [`AP_ROWS-1:0] tags_c,
  output par_wr_t             par_wr,
  output logic [`AP_ROWS-1:0] par_rows
);

  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    COMPARE,
    WRITE,
    DONE
  } state_e;

  localparam logic [`AP_COL_BITS-1:0] carry_sel = `AP_COL_BITS'(1) << `AP_WORD_BITS;

  state_e      state;
  op_e         op_q;
  logic [2:0]  bit_cnt;
  logic [2:0]  pass_cnt;
  logic [2:0]  pass_count;
  pass_entry_u entry;
  logic        is_add;
  logic        last_pass;
  logic        last_bit;

  logic [`AP_COL_BITS-1:0] bit_sel;

  // Per pass key and write bits taken from the matching table view
  logic key_a;
  logic key_b;
  logic key_carry;
  logic val_bit;
  logic val_carry;

  assign op_ready = (state == IDLE) && !req_valid;
  assign op_done  = (state == DONE);
  assign busy     = (state != IDLE);

  ////////////////////////////////////////////////////////////
  // Table decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    entry = pass_table(op_q, pass_cnt, pass_count);
  end

  assign is_add    = (op_q == OP_ADD);
  assign last_pass = (pass_cnt == pass_count - 3'd1);
  assign last_bit  = (bit_cnt == 3'(`AP_WORD_BITS - 1));
  assign bit_sel   = `AP_COL_BITS'(1) << bit_cnt;

  // Both views keep the operand keys in the same bits
  assign key_a     = entry.arith.key_a;
  assign key_b     = entry.arith.key_b;
  assign key_carry = is_add & entry.arith.key_carry;
  assign val_bit   = is_add ? entry.arith.val_sum : entry.lgc.val_c;
  assign val_carry = is_add & entry.arith.val_carry;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst) begin
      state    <= IDLE;
      op_q     <= OP_OR;
      bit_cnt  <= '0;
      pass_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (op_valid && op_ready) begin
            op_q     <= op;
            bit_cnt  <= '0;
            pass_cnt <= '0;
            state    <= CLEAR;
          end
        end
        CLEAR:   state <= COMPARE;
        COMPARE: state <= WRITE;
        WRITE: begin
          if (last_pass) begin
            pass_cnt <= '0;
            if (last_bit) begin
              state <= DONE;
            end else begin
              bit_cnt <= bit_cnt + 3'd1;
              state   <= COMPARE;
            end
          end else begin
            pass_cnt <= pass_cnt + 3'd1;
            state    <= COMPARE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Keys and masks are held for the following WRITE cycle
  always_ff @(posedge clock) begin
    if (state == COMPARE) begin
      search_a.key  <= {`AP_COL_BITS{key_a}} & bit_sel;
      search_a.mask <= bit_sel;
      search_b.key  <= {`AP_COL_BITS{key_b}} & bit_sel;
      search_b.mask <= bit_sel;
      // Result bit must still be clear and ADD also matches the carry
      search_c.key  <= {`AP_COL_BITS{key_carry}} & carry_sel;
      search_c.mask <= is_add ? (bit_sel | carry_sel) : bit_sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Parallel write into C
  ////////////////////////////////////////////////////////////

  always_comb begin
    par_wr   = '0;
    par_rows = tags_a & tags_b & tags_c;
    if (state == CLEAR) begin
      par_wr.en   = 1'b1;
      par_wr.mask = '1;
      par_rows    = '1;
    end else if (state == WRITE) begin
      par_wr.en   = 1'b1;
      par_wr.data = ({`AP_COL_BITS{val_bit}} & bit_sel)
                  | ({`AP_COL_BITS{val_carry}} & carry_sel);
      par_wr.mask = is_add ? (bit_sel | carry_sel) : bit_sel;
    end
  end

endmodule

/* rtl/host_port.sv */
`timescale 1ns/1ps
`include "ap_config.svh"

module host_port
  import ap_cam_pkg::*;
(
  input  logic                     clock,
  input  logic                     rst,
  input  host_req_t                req,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic                     busy,
  output host_wr_t                 wr_a,
  output host_wr_t                 wr_b,
  output host_wr_t                 wr_c,
  output logic [`AP_ROW_BITS-1:0]  read_row,
  input  logic [`AP_WORD_BITS-1:0] data_a,
  input  logic [`AP_WORD_BITS-1:0] data_b,
  input  logic [`AP_COL_BITS-1:0]  data_c,
  output logic [`AP_COL_BITS-1:0]  rsp_data,
  output logic                     rsp_valid
);

  logic accept;
  logic wr_accept;

  assign req_ready = !busy;
  assign accept    = req_valid && req_ready;
  assign wr_accept = accept && req.write;
  assign read_row  = req.row;

  // One hot column write decode
  always_comb begin
    wr_a    = '{en: wr_accept && (req.col == COL_A), row: req.row, data: req.data};
    wr_b    = '{en: wr_accept && (req.col == COL_B), row: req.row, data: req.data};
    wr_c    = '{en: wr_accept && (req.col == COL_C), row: req.row, data: req.data};
  end

  ////////////////////////////////////////////////////////////
  // Read response, one cycle after acceptance
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= accept && !req.write;
    end
  end

  always_ff @(posedge clock) begin
    case (req.col)
      COL_A:   rsp_data <= {1'b0, data_a};
      COL_B:   rsp_data <= {1'b0, data_b};
      default: rsp_data <= data_c;
    endcase
  end

endmodule

/* rtl/ap_top.sv */
`timescale 1ns/1ps
`include "ap_config.svh"

module ap_top
  import ap_cam_pkg::*;
  import ap_op_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst,
  input  host_req_t               req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output logic [`AP_COL_BITS-1:0] rsp_data,
  output logic                    rsp_valid,
  input  op_e                     op,
  input  logic                    op_valid,
  output logic                    op_ready,
  output logic                    op_done
);

  logic                     busy;
  host_wr_t                 wr_a;
  host_wr_t                 wr_b;
  host_wr_t                 wr_c;
  logic [`AP_ROW_BITS-1:0]  read_row;
  logic [`AP_WORD_BITS-1:0] data_a;
  logic [`AP_WORD_BITS-1:0] data_b;
  logic [`AP_COL_BITS-1:0]  data_c;
  search_t                  search_a;
  search_t                  search_b;
  search_t                  search_c;
  logic [`AP_ROWS-1:0]      tags_a;
  logic [`AP_ROWS-1:0]      tags_b;
  logic [`AP_ROWS-1:0]      tags_c;
  par_wr_t                  par_wr;
  logic [`AP_ROWS-1:0]      par_rows;

  ////////////////////////////////////////////////////////////
  // Columns
  ////////////////////////////////////////////////////////////

  // Operand columns are never written in parallel
  cam_column #(.WIDTH(`AP_WORD_BITS)) col_a (
    .clock     (clock),
    .rst       (rst),
    .host_wr   (wr_a),
    .read_row  (read_row),
    .read_data (data_a),
    .search    (search_a),
    .tags      (tags_a),
    .par_wr    ('0),
    .par_rows  ('0)
  );

  cam_column #(.WIDTH(`AP_WORD_BITS)) col_b (
    .clock     (clock),
    .rst       (rst),
    .host_wr   (wr_b),
    .read_row  (read_row),
    .read_data (data_b),
    .search    (search_b),
    .tags      (tags_b),
    .par_wr    ('0),
    .par_rows  ('0)
  );

  cam_column #(.WIDTH(`AP_COL_BITS)) col_c (
    .clock     (clock),
    .rst       (rst),
    .host_wr   (wr_c),
    .read_row  (read_row),
    .read_data (data_c),
    .search    (search_c),
    .tags      (tags_c),
    .par_wr    (par_wr),
    .par_rows  (par_rows)
  );

  ////////////////////////////////////////////////////////////
  // Control and host access
  ////////////////////////////////////////////////////////////

  pass_sequencer u_seq (
    .clock     (clock),
    .rst       (rst),
    .op        (op),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op_done   (op_done),
    .req_valid (req_valid),
    .busy      (busy),
    .search_a  (search_a),
    .search_b  (search_b),
    .search_c  (search_c),
    .tags_a    (tags_a),
    .tags_b    (tags_b),
    .tags_c    (tags_c),
    .par_wr    (par_wr),
    .par_rows  (par_rows)
  );

  host_port u_host (
    .clock     (clock),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .busy      (busy),
    .wr_a      (wr_a),
    .wr_b      (wr_b),
    .wr_c      (wr_c),
    .read_row  (read_row),
    .data_a    (data_a),
    .data_b    (data_b),
    .data_c    (data_c),
    .rsp_data  (rsp_data),
    .rsp_valid (rsp_valid)
  );

endmodule

/* verif/ap_checker.sv */
`timescale 1ns/1ps
`include "ap_config.svh"

module ap_checker
  import ap_cam_pkg::*;
  import ap_op_pkg::*;
(
  input  logic                                  clock,
  input  logic                                  rst,
  input  host_req_t                             req,
  input  logic                                  req_valid,
  input  logic                                  req_ready,
  input  logic [`AP_COL_BITS-1:0]               rsp_data,
  input  logic                                  rsp_valid,
  input  logic                                  op_valid,
  input  logic                                  op_ready,
  input  logic                                  op_done,
  input  logic [`AP_ROWS-1:0][`AP_COL_BITS-1:0] model_a,
  input  logic [`AP_ROWS-1:0][`AP_COL_BITS-1:0] model_b,
  input  logic [`AP_ROWS-1:0][`AP_COL_BITS-1:0] model_c,
  output int                                    error_count,
  output int                                    rsp_count
);

  logic                    rd_pending;
  logic [`AP_COL_BITS-1:0] rd_expect;
  logic [1:0]              rd_col;
  logic [`AP_ROW_BITS-1:0] rd_row;
  logic                    in_op;

  initial begin
    error_count = 0;
    rsp_count   = 0;
  end

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    error_count++;
  endtask

  function automatic logic [`AP_COL_BITS-1:0] model_word(input column_e col,
                                                         input logic [`AP_ROW_BITS-1:0] row);
    case (col)
      COL_A:   return model_a[row];
      COL_B:   return model_b[row];
      default: return model_c[row];
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Response and handshake rules
  ////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (rst) begin
      rd_pending <= 1'b0;
      in_op      <= 1'b0;
    end else begin
      // Responses actually delivered by the DUT
      if (rsp_valid === 1'b1) begin
        rsp_count++;
      end
      // Read data is due one cycle after acceptance
      if (rd_pending) begin
        if (rsp_valid !== 1'b1) begin
          report_error($sformatf("no response for read of column %0d row %0d", rd_col, rd_row));
        end else if (rsp_data !== rd_expect) begin
          report_error($sformatf("column %0d row %0d read 0x%03h, expected 0x%03h",
                                 rd_col, rd_row, rsp_data, rd_expect));
        end
      end else if (rsp_valid !== 1'b0) begin
        report_error("rsp_valid high without an accepted read");
      end
      if (op_done !== 1'b0 && !in_op) begin
        report_error("op_done pulse without a running operation");
      end
      if (in_op && req_ready !== 1'b0) begin
        report_error("req_ready high during an operation");
      end
      if (!in_op && req_ready !== 1'b1) begin
        report_error("req_ready low while idle");
      end
      if (req_valid && op_ready !== 1'b0) begin
        report_error("op_ready high while req_valid is high");
      end
      rd_pending <= req_valid && req_ready && !req.write;
      rd_col     <= req.col;
      rd_row     <= req.row;
      rd_expect  <= model_word(req.col, req.row);
      if (op_valid && op_ready) begin
        in_op <= 1'b1;
      end else if (op_done) begin
        in_op <= 1'b0;
      end
    end
  end

endmodule

/* verif/ap_tb.sv */
`timescale 1ns/1ps
`include "ap_config.svh"

module ap_tb
  import ap_cam_pkg::*;
  import ap_op_pkg::*;
();

  localparam int HANDSHAKE_LIMIT = 20;
  localparam int OP_LIMIT        = 200;

  logic                    clock;
  logic                    rst;
  host_req_t               req;
  logic                    req_valid;
  logic                    req_ready;
  logic [`AP_COL_BITS-1:0] rsp_data;
  logic                    rsp_valid;
  op_e                     op;
  logic                    op_valid;
  logic                    op_ready;
  logic                    op_done;

  // Reference copy of the three columns with A and B zero extended
  logic [`AP_ROWS-1:0][`AP_COL_BITS-1:0] model_a;
  logic [`AP_ROWS-1:0][`AP_COL_BITS-1:0] model_b;
  logic [`AP_ROWS-1:0][`AP_COL_BITS-1:0] model_c;

  int  seed;
  int  timeouts;
  int  reads_issued;
  int  error_count;
  int  rsp_count;
  int  lost_responses;
  op_e op_list [5];

  ap_top ap_top_inst (
    .clock     (clock),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_data  (rsp_data),
    .rsp_valid (rsp_valid),
    .op        (op),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op_done   (op_done)
  );

  ap_checker ap_checker_inst (
    .clock       (clock),
    .rst         (rst),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .rsp_data    (rsp_data),
    .rsp_valid   (rsp_valid),
    .op_valid    (op_valid),
    .op_ready    (op_ready),
    .op_done     (op_done),
    .model_a     (model_a),
    .model_b     (model_b),
    .model_c     (model_c),
    .error_count (error_count),
    .rsp_count   (rsp_count)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [`AP_COL_BITS-1:0] reference_result(input op_e code,
      input logic [`AP_COL_BITS-1:0] a, input logic [`AP_COL_BITS-1:0] b);
    logic [`AP_WORD_BITS-1:0] wa;
    logic [`AP_WORD_BITS-1:0] wb;
    wa = a[`AP_WORD_BITS-1:0];
    wb = b[`AP_WORD_BITS-1:0];
    case (code)
      OP_OR:   return {1'b0, wa | wb};
      OP_XOR:  return {1'b0, wa ^ wb};
      OP_AND:  return {1'b0, wa & wb};
      OP_NOT:  return {1'b0, ~wa};
      default: return {1'b0, wa} + {1'b0, wb};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Host and operation handshakes
  ////////////////////////////////////////////////////////////

  task automatic present_request(input logic write, input column_e col,
                                 input logic [`AP_ROW_BITS-1:0] row,
                                 input logic [`AP_WORD_BITS-1:0] data);
    req       = '{write: write, col: col, row: row, data: data};
    req_valid = 1'b1;
  endtask

  // Waits for the transfer and mirrors a write into the model
  task automatic complete_request(input string what);
    int n;
    n = 0;
    @(posedge clock);
    while (!(req_valid && req_ready) && n < HANDSHAKE_LIMIT) begin
      n++;
      @(posedge clock);
    end
    if (!(req_valid && req_ready)) begin
      $display("Timeout: the %s request was never accepted", what);
      timeouts++;
    end else if (!req.write) begin
      reads_issued++;
    end else begin
      case (req.col)
        COL_A:   model_a[req.row] = {1'b0, req.data};
        COL_B:   model_b[req.row] = {1'b0, req.data};
        default: model_c[req.row] = {1'b0, req.data};
      endcase
    end
    @(negedge clock);
    req_valid = 1'b0;
  endtask

  task automatic host_write(input column_e col, input logic [`AP_ROW_BITS-1:0] row,
                            input logic [`AP_WORD_BITS-1:0] data);
    present_request(1'b1, col, row, data);
    complete_request("write");
  endtask

  task automatic host_read(input column_e col, input logic [`AP_ROW_BITS-1:0] row);
    present_request(1'b0, col, row, '0);
    complete_request("read");
  endtask

  task automatic run_op(input op_e code);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    // Host read offered together with the operation wins first
    op       = code;
    op_valid = 1'b1;
    present_request(1'b0, COL_C, `AP_ROW_BITS'($random(seed)), '0);
    complete_request("contending read");
    @(posedge clock);
    while (!(op_valid && op_ready) && n < HANDSHAKE_LIMIT) begin
      n++;
      @(posedge clock);
    end
    if (!(op_valid && op_ready)) begin
      $display("Timeout: operation %0d was never accepted", code);
      timeouts++;
    end
    @(negedge clock);
    op_valid = 1'b0;
    // This read is held until the operation has finished
    present_request(1'b0, COL_C, `AP_ROW_BITS'($random(seed)), '0);
    n = 0;
    while (!seen && n < OP_LIMIT) begin
      @(posedge clock);
      seen = op_done;
      n++;
    end
    if (!seen) begin
      $display("Timeout: operation %0d never signalled op_done", code);
      timeouts++;
    end else begin
      for (int r = 0; r < `AP_ROWS; r++) begin
        model_c[r] = reference_result(code, model_a[r], model_b[r]);
      end
    end
    complete_request("held read");
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    seed           = 89237;
    timeouts       = 0;
    reads_issued   = 0;
    lost_responses = 0;
    op_list        = '{OP_OR, OP_XOR, OP_AND, OP_NOT, OP_ADD};
    model_a        = '0;
    model_b        = '0;
    model_c        = '0;
    rst            = 1'b1;
    req            = '0;
    req_valid      = 1'b0;
    op             = OP_OR;
    op_valid       = 1'b0;
    repeat (4) @(negedge clock);
    rst = 1'b0;
    // Idle cycles while the checker watches the outputs after reset
    repeat (4) @(negedge clock);

    for (int r = 0; r < `AP_ROWS; r++) begin
      host_write(COL_A, `AP_ROW_BITS'(r), 8'($random(seed)));
      host_write(COL_B, `AP_ROW_BITS'(r), 8'($random(seed)));
      host_write(COL_C, `AP_ROW_BITS'(r), 8'($random(seed)));
    end
    repeat (40) begin
      host_read(column_e'($unsigned($random(seed)) % 3), `AP_ROW_BITS'($random(seed)));
    end

    for (int i = 0; i < 5; i++) begin
      for (int r = 0; r < `AP_ROWS; r++) begin
        host_write(COL_A, `AP_ROW_BITS'(r), 8'($random(seed)));
        host_write(COL_B, `AP_ROW_BITS'(r), 8'($random(seed)));
      end
      if (op_list[i] == OP_ADD) begin
        host_write(COL_A, 0, 8'hff);
        host_write(COL_B, 0, 8'hff);
        host_write(COL_A, 1, 8'h00);
        host_write(COL_B, 1, 8'h00);
      end
      run_op(op_list[i]);
      for (int r = 0; r < `AP_ROWS; r++) begin
        host_read(COL_C, `AP_ROW_BITS'(r));
      end
      host_read(COL_A, `AP_ROW_BITS'($random(seed)));
      host_read(COL_B, `AP_ROW_BITS'($random(seed)));
    end

    repeat (2) @(negedge clock);
    if (rsp_count != reads_issued) begin
      $display("Response count mismatch: %0d reads accepted, %0d responses received",
               reads_issued, rsp_count);
      lost_responses = 1;
    end
    $display("Error counts: checker %0d, timeouts %0d, response count %0d",
             error_count, timeouts, lost_responses);
    if (error_count == 0 && timeouts == 0 && lost_responses == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/ap_cam_pkg.sv
rtl/ap_op_pkg.sv
rtl/cam_column.sv
rtl/pass_sequencer.sv
rtl/host_port.sv
rtl/ap_top.sv
verif/ap_checker.sv
verif/ap_tb.sv

/* Bender.yml */
package:
  name: ap_cam

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ap_cam_pkg.sv
      - rtl/ap_op_pkg.sv
      - rtl/cam_column.sv
      - rtl/pass_sequencer.sv
      - rtl/host_port.sv
      - rtl/ap_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/ap_checker.sv
      - verif/ap_tb.sv
